/* verilog.f */
verilog/hss_link_pkg.sv
verilog/hss_tx_control.sv
verilog/hss_word_aligner.sv
verilog/hss_rx_control.sv
verilog/hss_link_control.sv
test/hss_link_control_sva.sv
test/hss_link_control_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= hss_link_control_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* test/hss_link_control_tb.sv */
`timescale 1ns/100ps

module hss_link_control_tb import hss_link_pkg::*;
();

  // Run length
  int clk_period      = 10;
  int reset_cycles    = 16;
  int slip_count      = 4;
  int words_per_slip  = 250;
  int hs_bound_cycles = 300;
  int drain_cycles    = 8;

  // Expected link-control words, built from the K-character codes
  logic [31:0] clkc_expected = {4{kch_clkc}};
  int          cc_period     = int'(clock_correction_interval) + 1;

  logic        clk_in;
  logic        reset_in;
  logic [31:0] tx_data_i;
  logic [3:0]  tx_charisk_i;
  logic [31:0] rx_data_i;
  logic [3:0]  rx_charisk_i;
  logic [31:0] tx_data_o;
  logic [3:0]  tx_charisk_o;
  logic        tx_rdy_o;
  logic [31:0] rx_data_o;
  logic [3:0]  rx_charisk_o;
  logic        rx_vld_o;
  logic        handshake_complete_o;

  // Channel and scoreboard state
  logic [1:0]  slip;
  logic [31:0] line_data;
  logic [3:0]  line_charisk;
  logic        flushing;
  logic        draining;
  logic        prev_complete;
  logic        prev_rdy_low;
  logic        saw_phase1;
  logic        clkc_run;
  int          cycle;
  int          last_clkc;
  int          pushed;
  logic [31:0] model_q[$];

  hss_link_control dut
  (
    .clk_in               (clk_in),
    .reset_in             (reset_in),
    .tx_data_o            (tx_data_o),
    .tx_charisk_o         (tx_charisk_o),
    .tx_data_i            (tx_data_i),
    .tx_charisk_i         (tx_charisk_i),
    .tx_rdy_o             (tx_rdy_o),
    .rx_data_i            (rx_data_i),
    .rx_charisk_i         (rx_charisk_i),
    .rx_data_o            (rx_data_o),
    .rx_charisk_o         (rx_charisk_o),
    .rx_vld_o             (rx_vld_o),
    .handshake_complete_o (handshake_complete_o)
  );

  bind hss_link_control hss_link_control_sva sva
  (
    .clk_in               (clk_in),
    .reset_in             (reset_in),
    .tx_data_i            (tx_data_o),
    .tx_charisk_i         (tx_charisk_o),
    .tx_rdy_i             (tx_rdy_o),
    .rx_vld_i             (rx_vld_o),
    .handshake_complete_i (handshake_complete_o)
  );

  always #(clk_period / 2) clk_in = ~clk_in;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
      stop_run($sformatf("FAIL at %0d ns: %s is 0x%0h, expected 0x%0h",
                         $time, what, actual, expected));
  endtask

  task automatic check_reset_outputs();
    check_value(32'(tx_rdy_o), 32'd0, "tx_rdy_o in reset");
    check_value(32'(rx_vld_o), 32'd0, "rx_vld_o in reset");
    check_value(32'(handshake_complete_o), 32'd0, "handshake_complete_o in reset");
    check_value(tx_data_o, 32'd0, "tx_data_o in reset");
    check_value(32'(tx_charisk_o), 32'd0, "tx_charisk_o in reset");
  endtask

  // Words sent while the previous cycle was not ready come from the handshake path
  task automatic check_tx_word();
    logic [31:0] expected;
    if (!reset_in && prev_rdy_low)
    begin
      if (tx_charisk_o == 4'b1111)
      begin
        check_value(tx_data_o, clkc_expected, "clock-correction word");
        if (clkc_run)
          check_value(cycle - last_clkc, cc_period, "clock-correction spacing");
        clkc_run  = 1'b1;
        last_clkc = cycle;
      end
      else
      begin
        // Phase bit is free, the rest is fixed
        expected = {kch_comma, kch_handshake, 7'b0000000, tx_data_o[8], protocol_version};
        check_value(32'(tx_charisk_o), 32'(4'b1100), "handshake K flags");
        check_value(tx_data_o, expected, "handshake word");
        check_value(32'(cycle - last_clkc < cc_period), 32'd1, "clock-correction overdue");
        if (tx_data_o[8])
          saw_phase1 = 1'b1;
      end
    end
    else
    begin
      // First clock-correction word of a handshake run is due within one period
      clkc_run  = 1'b0;
      last_clkc = cycle;
    end
  endtask

  task automatic check_rx_word();
    logic [31:0] expected;
    if (rx_vld_o)
    begin
      if (rx_charisk_o == 4'b1111 && rx_data_o == clkc_expected)
        stop_run("Clock-correction word was passed to the user receive side");
      else if (!flushing)
      begin
        if (model_q.size() == 0)
          stop_run("Receive strobe with no word left in the reference queue");
        else
        begin
          expected = model_q.pop_front();
          check_value(rx_data_o, expected, "rx_data_o");
          check_value(32'(rx_charisk_o), 32'd0, "rx_charisk_o");
        end
      end
    end
  endtask

  task automatic check_status();
    if (reset_in)
      check_reset_outputs();
    // Ready trails link up by one cycle
    check_value(32'(tx_rdy_o), 32'(prev_complete), "tx_rdy_o");
    if (handshake_complete_o && !prev_complete)
      check_value(32'(saw_phase1), 32'd1, "phase 1 handshake seen before completion");
    if (!handshake_complete_o && prev_complete)
      saw_phase1 = 1'b0;
    prev_complete = handshake_complete_o;
    prev_rdy_low  = !tx_rdy_o;
  endtask

  task automatic drive_inputs();
    logic [63:0] pair_data;
    logic [7:0]  pair_charisk;
    // Slipped channel, tail bytes of the previous word come first
    pair_data    = {line_data, tx_data_o};
    pair_charisk = {line_charisk, tx_charisk_o};
    rx_data_i    = pair_data[8*slip +: 32];
    rx_charisk_i = pair_charisk[slip +: 4];
    line_data    = tx_data_o;
    line_charisk = tx_charisk_o;
    // User words with clock correction mixed in
    if (draining || $urandom_range(7) == 0)
    begin
      tx_data_i    = clkc_expected;
      tx_charisk_i = 4'b1111;
    end
    else
    begin
      tx_data_i    = $urandom;
      tx_charisk_i = 4'b0000;
    end
    // Taken by the DUT when ready is high in this cycle
    if (tx_rdy_o && !flushing && !draining && tx_charisk_i == 4'b0000)
    begin
      model_q.push_back(tx_data_i);
      pushed++;
    end
  endtask

  // One clock, outputs sampled and inputs driven on the falling edge
  task automatic step();
    @(negedge clk_in);
    cycle++;
    check_tx_word();
    check_rx_word();
    check_status();
    drive_inputs();
  endtask

  initial
  begin
    void'($urandom(44539));
    clk_in        = 1'b0;
    reset_in      = 1'b1;
    tx_data_i     = '0;
    tx_charisk_i  = '0;
    rx_data_i     = '0;
    rx_charisk_i  = '0;
    slip          = 2'd0;
    line_data     = '0;
    line_charisk  = '0;
    flushing      = 1'b0;
    draining      = 1'b0;
    prev_complete = 1'b0;
    prev_rdy_low  = 1'b1;
    saw_phase1    = 1'b0;
    clkc_run      = 1'b0;
    cycle         = 0;
    last_clkc     = 0;
    pushed        = 0;
    repeat (reset_cycles) step();
    reset_in = 1'b0;
    check_reset_outputs();
    for (int s = 0; s < slip_count; s++)
    begin
      if (s != 0)
      begin
        // New slip, in-flight words are lost until the link is back
        flushing = 1'b1;
        draining = 1'b0;
        slip     = 2'(s);
        while (handshake_complete_o)
          step();
        model_q.delete();
      end
      while (!handshake_complete_o)
        step();
      flushing = 1'b0;
      pushed   = 0;
      while (pushed < words_per_slip)
        step();
      // Only clock correction until every word is back
      draining = 1'b1;
      while (model_q.size() != 0)
        step();
      repeat (drain_cycles) step();
    end
    $display("*** PASSED ***");
    $finish;
  end

  // Bound from the handshake, transfer and drain budget of every slip
  initial
  begin
    #((reset_cycles + slip_count * (hs_bound_cycles + 2 * words_per_slip + drain_cycles))
      * clk_period);
    stop_run("Watchdog expired before all tests finished");
  end

endmodule

/* test/hss_link_control_sva.sv */
`timescale 1ns/100ps

module hss_link_control_sva
(
  input logic        clk_in,
  input logic        reset_in,
  input logic [31:0] tx_data_i,
  input logic [3:0]  tx_charisk_i,
  input logic        tx_rdy_i,
  input logic        rx_vld_i,
  input logic        handshake_complete_i
);

  // Ready is the link status one cycle late
  ready_follows_link: assert property (@(posedge clk_in) disable iff (reset_in)
    !$past(reset_in) |-> tx_rdy_i == $past(handshake_complete_i))
    else $error("tx_rdy_o does not follow handshake_complete_o");

  // User words only once the link is up
  vld_needs_link: assert property (@(posedge clk_in) disable iff (reset_in)
    rx_vld_i |-> handshake_complete_i)
    else $error("rx_vld_o high without handshake_complete_o");

  // Second reset edge onward, everything held at zero
  reset_state: assert property (@(posedge clk_in)
    reset_in && $past(reset_in) |->
      !tx_rdy_i && !rx_vld_i && !handshake_complete_i &&
      tx_data_i == 32'd0 && tx_charisk_i == 4'd0)
    else $error("outputs not in reset state while reset is high");

endmodule

/* verilog/hss_link_control.sv */
`timescale 1ns/100ps

module hss_link_control
(
  input  logic        clk_in,
  input  logic        reset_in,

  // To the serial transmitter
  output logic [31:0] tx_data_o,
  output logic [3:0]  tx_charisk_o,

  // User transmit, word taken when ready is high
  input  logic [31:0] tx_data_i,
  input  logic [3:0]  tx_charisk_i,
  output logic        tx_rdy_o,

  // From the serial receiver, raw
  input  logic [31:0] rx_data_i,
  input  logic [3:0]  rx_charisk_i,

  // User receive
  output logic [31:0] rx_data_o,
  output logic [3:0]  rx_charisk_o,
  output logic        rx_vld_o,

  // Link up
  output logic        handshake_complete_o
);

  logic        handshake_phase;
  logic [31:0] aligned_data;
  logic [3:0]  aligned_charisk;
  logic        aligned_vld;
  logic        sync_lost;

  // Handshake, clock correction and user word mux
  hss_tx_control tx_control
  (
    .clk_in               (clk_in),
    .reset_in             (reset_in),
    .handshake_complete_i (handshake_complete_o),
    .handshake_phase_i    (handshake_phase),
    .tx_data_i            (tx_data_i),
    .tx_charisk_i         (tx_charisk_i),
    .tx_data_o            (tx_data_o),
    .tx_charisk_o         (tx_charisk_o),
    .tx_rdy_o             (tx_rdy_o)
  );

  // Comma-based word alignment of the raw stream
  hss_word_aligner word_aligner
  (
    .clk_in            (clk_in),
    .reset_in          (reset_in),
    .raw_data_i        (rx_data_i),
    .raw_charisk_i     (rx_charisk_i),
    .aligned_data_o    (aligned_data),
    .aligned_charisk_o (aligned_charisk),
    .aligned_vld_o     (aligned_vld),
    .sync_lost_o       (sync_lost)
  );

  // Handshake FSM and receive filtering
  hss_rx_control rx_control
  (
    .clk_in               (clk_in),
    .reset_in             (reset_in),
    .aligned_data_i       (aligned_data),
    .aligned_charisk_i    (aligned_charisk),
    .aligned_vld_i        (aligned_vld),
    .sync_lost_i          (sync_lost),
    .rx_data_o            (rx_data_o),
    .rx_charisk_o         (rx_charisk_o),
    .rx_vld_o             (rx_vld_o),
    .handshake_complete_o (handshake_complete_o),
    .handshake_phase_o    (handshake_phase)
  );

endmodule

/* verilog/hss_rx_control.sv */
`timescale 1ns/100ps

module hss_rx_control import hss_link_pkg::*;
(
  input  logic        clk_in,
  input  logic        reset_in,

  // From the word aligner
  input  logic [31:0] aligned_data_i,
  input  logic [3:0]  aligned_charisk_i,
  input  logic        aligned_vld_i,
  input  logic        sync_lost_i,

  // User receive side, strobe per word
  output logic [31:0] rx_data_o,
  output logic [3:0]  rx_charisk_o,
  output logic        rx_vld_o,

  // Handshake status, also read by the transmit side
  output logic        handshake_complete_o,
  output logic        handshake_phase_o
);

  hs_state_t state;
  hs_state_t state_next;
  logic      is_clkc;
  logic      is_handshake;
  logic      hs_good;
  logic      hs_phase;
  logic      hs_valid;
  logic      restart;

  // Word classification
  assign is_clkc = (aligned_charisk_i == clkc_charisk) &&
                   (aligned_data_i == clkc_word);

  assign is_handshake = (aligned_charisk_i == hs_charisk) &&
                        (aligned_data_i[31:24] == kch_comma) &&
                        (aligned_data_i[23:16] == kch_handshake);

  // Reserved phase bits zero and same version as ours
  assign hs_good  = (aligned_data_i[15:9] == 7'd0) &&
                    (aligned_data_i[7:0] == protocol_version);
  assign hs_phase = aligned_data_i[8];

  assign hs_valid = aligned_vld_i && is_handshake && hs_good;

  // Lost lanes or an incompatible peer start everything over
  assign restart = sync_lost_i || (aligned_vld_i && is_handshake && !hs_good);

  // Handshake FSM
  always_comb
  begin
    state_next = state;
    if (restart)
      state_next = HS_SEARCH;
    else
    begin
      unique case (state)
        HS_SEARCH:
        begin
          // Any good handshake word, either phase
          if (hs_valid)
            state_next = HS_ACK;
        end
        HS_ACK:
        begin
          // Far end has seen us too
          if (hs_valid && hs_phase)
            state_next = HS_DONE;
        end
        HS_DONE:
          state_next = HS_DONE;
        default:
          state_next = HS_SEARCH;
      endcase
    end
  end

  always_ff @(posedge clk_in or posedge reset_in)
  begin
    if (reset_in)
      state <= HS_SEARCH;
    else
      state <= state_next;
  end

  assign handshake_complete_o = (state == HS_DONE);
  assign handshake_phase_o    = (state != HS_SEARCH);

  // User strobe
  // Link-control words never reach the user, restart word is dropped
  always_ff @(posedge clk_in or posedge reset_in)
  begin
    if (reset_in)
      rx_vld_o <= 1'b0;
    else
      rx_vld_o <= (state == HS_DONE) && aligned_vld_i &&
                  !is_clkc && !is_handshake && !restart;
  end

  // Payload follows the strobe by construction
  always_ff @(posedge clk_in)
  begin
    rx_data_o    <= aligned_data_i;
    rx_charisk_o <= aligned_charisk_i;
  end

endmodule

/* verilog/hss_word_aligner.sv */
`timescale 1ns/100ps

module hss_word_aligner import hss_link_pkg::*;
(
  input  logic        clk_in,
  input  logic        reset_in,

  // Raw words from the serial receiver, possibly byte-slipped
  input  logic [31:0] raw_data_i,
  input  logic [3:0]  raw_charisk_i,

  // Realigned words, comma in lane 3
  output logic [31:0] aligned_data_o,
  output logic [3:0]  aligned_charisk_o,
  output logic        aligned_vld_o,
  output logic        sync_lost_o
);

  logic [31:0] prev_data;
  logic [3:0]  prev_charisk;
  logic [1:0]  offset;
  logic        locked;
  logic [63:0] combined_data;
  logic [7:0]  combined_charisk;
  logic [31:0] window_data;
  logic [3:0]  window_charisk;
  logic        comma_found;
  logic [1:0]  comma_lane;
  logic        clkc_seen;
  logic        clkc_bad;
  logic [1:0]  new_offset;

  // Byte stream runs from high lanes to low lanes
  // Previous word holds the earlier bytes
  assign combined_data    = {prev_data, raw_data_i};
  assign combined_charisk = {prev_charisk, raw_charisk_i};

  // Offset 0 is the current raw word, each step pulls in one earlier byte
  assign window_data    = combined_data[8*offset +: 32];
  assign window_charisk = combined_charisk[offset +: 4];

  // Lane search in the rotated word
  // Upper lanes win, so a comma already in lane 3 keeps the offset
  always_comb
  begin
    comma_found = 1'b0;
    comma_lane  = 2'd3;
    clkc_seen   = 1'b0;
    for (int lane = 0; lane < 4; lane++)
    begin
      if (window_charisk[lane] && window_data[8*lane +: 8] == kch_comma)
      begin
        comma_found = 1'b1;
        comma_lane  = 2'(lane);
      end
      if (window_charisk[lane] && window_data[8*lane +: 8] == kch_clkc)
        clkc_seen = 1'b1;
    end
  end

  // A clock-correction character in a partial word means the lanes moved
  // Its own alignment cannot be recovered, wait for the next comma
  assign clkc_bad = locked && !comma_found && clkc_seen &&
                    (window_charisk != clkc_charisk);

  // Comma byte lands in lane 3 of the word that starts with it
  // Wraps modulo 4, lane 3 gives back the current offset
  assign new_offset = offset + comma_lane + 2'd1;

  always_ff @(posedge clk_in or posedge reset_in)
  begin
    if (reset_in)
    begin
      offset        <= 2'd0;
      locked        <= 1'b0;
      aligned_vld_o <= 1'b0;
      sync_lost_o   <= 1'b0;
    end
    else
    begin
      if (comma_found)
      begin
        offset <= new_offset;
        locked <= 1'b1;
      end
      else if (clkc_bad)
        locked <= 1'b0;

      // Nothing valid before the first comma
      aligned_vld_o <= comma_found || (locked && !clkc_bad);
      // Pulse in the same output cycle as the offending word
      sync_lost_o   <= (comma_found && comma_lane != 2'd3) || clkc_bad;
    end
  end

  // Data path registers
  always_ff @(posedge clk_in)
  begin
    prev_data         <= raw_data_i;
    prev_charisk      <= raw_charisk_i;
    aligned_data_o    <= window_data;
    aligned_charisk_o <= window_charisk;
  end

endmodule

/* verilog/hss_tx_control.sv */
`timescale 1ns/100ps

module hss_tx_control import hss_link_pkg::*;
(
  input  logic        clk_in,
  input  logic        reset_in,

  // Link state from the receive side
  input  logic        handshake_complete_i,
  input  logic        handshake_phase_i,

  // User words, taken in any cycle with tx_rdy_o high
  input  logic [31:0] tx_data_i,
  input  logic [3:0]  tx_charisk_i,

  // Towards the serial transmitter
  output logic [31:0] tx_data_o,
  output logic [3:0]  tx_charisk_o,
  output logic        tx_rdy_o
);

  logic [clock_correction_bits-1:0] cc_count;
  logic                             cc_due;
  logic                             send_handshake;
  logic                             send_clkc;

  // Free-running interval counter
  // Only matters while handshaking, user side handles it afterwards
  always_ff @(posedge clk_in or posedge reset_in)
  begin
    if (reset_in)
      cc_count <= '0;
    else if (cc_count == clock_correction_interval)
      cc_count <= '0;
    else
      cc_count <= cc_count + 1'b1;
  end

  // One cycle after the wrap
  assign cc_due = (cc_count == '0);

  // Word selection runs one cycle behind the handshake status
  // So the first ready cycle still shows a handshake word
  always_ff @(posedge clk_in or posedge reset_in)
  begin
    if (reset_in)
    begin
      send_handshake <= 1'b1;
      send_clkc      <= 1'b0;
    end
    else
    begin
      send_handshake <= !handshake_complete_i;
      send_clkc      <= cc_due;
    end
  end

  // Output word register
  // Zero in reset keeps illegal K-characters off the line
  always_ff @(posedge clk_in or posedge reset_in)
  begin
    if (reset_in)
    begin
      tx_data_o    <= '0;
      tx_charisk_o <= '0;
    end
    else if (send_handshake)
    begin
      if (send_clkc)
      begin
        tx_data_o    <= clkc_word;
        tx_charisk_o <= clkc_charisk;
      end
      else
      begin
        // Phase tells the far end how far our receiver got
        tx_data_o    <= handshake_word(handshake_phase_i);
        tx_charisk_o <= hs_charisk;
      end
    end
    else
    begin
      // Link up, user words pass unchanged
      tx_data_o    <= tx_data_i;
      tx_charisk_o <= tx_charisk_i;
    end
  end

  // Ready is the handshake status one cycle late
  always_ff @(posedge clk_in or posedge reset_in)
  begin
    if (reset_in)
      tx_rdy_o <= 1'b0;
    else
      tx_rdy_o <= handshake_complete_i;
  end

endmodule

/* verilog/hss_link_pkg.sv */
package hss_link_pkg;

  // K28.5 comma
  // Always sits in byte lane 3 of a handshake word
  localparam logic [7:0] kch_comma = 8'hBC;

  // K28.0 marks a handshake word, lane 2
  localparam logic [7:0] kch_handshake = 8'h1C;

  // K28.3 clock-correction character
  // Repeated in all four lanes
  localparam logic [7:0] kch_clkc = 8'h7C;

  // Version carried in lane 0 of every handshake word
  localparam logic [7:0] protocol_version = 8'h01;

  // Clock correction during handshaking
  // Counter wraps every interval+1 cycles
  localparam int clock_correction_bits = 4;
  localparam logic [clock_correction_bits-1:0] clock_correction_interval = 4'd15;

  // K flags of the two link-control words
  localparam logic [3:0] hs_charisk   = 4'b1100;
  localparam logic [3:0] clkc_charisk = 4'b1111;

  // Full clock-correction word
  localparam logic [31:0] clkc_word = {4{kch_clkc}};

  // Handshake FSM
  // SEARCH sends phase 0, ACK and DONE send phase 1
  typedef enum logic [1:0]
  {
    HS_SEARCH,
    HS_ACK,
    HS_DONE
  } hs_state_t;

  // Handshake word
  // Lane 3 comma, lane 2 marker, lane 1 phase in bit 0, lane 0 version
  function automatic logic [31:0] handshake_word(input logic phase);
    handshake_word = {kch_comma, kch_handshake, 7'b0000000, phase, protocol_version};
  endfunction

endpackage
